/* logic/sys_pkg.sv */
////////////////////////////////////////
// Widths, address map and response codes of the host subsystem
// Regions are decoded from address bits 15:12 only, so upper bits alias
////////////////////////////////////////
`default_nettype none

package sys_pkg;

  // Bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  localparam int gpio_width = 8;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;
  typedef logic [1:0]            resp_t;
  typedef logic [gpio_width-1:0] gpio_t;

  // AXI response codes
  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;
  localparam resp_t resp_decerr = 2'b11;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////
  localparam addr_t region_mask  = 32'h0000_f000;
  localparam addr_t offset_mask  = 32'h0000_0fff;
  localparam addr_t scratch_base = 32'h0000_0000;
  localparam addr_t gpio_base    = 32'h0000_1000;

  // Scratch region offsets
  localparam addr_t id_off        = 32'h0000_0000;
  localparam addr_t scratch_first = 32'h0000_0004;
  localparam addr_t scratch_last  = 32'h0000_0010;
  localparam int    scratch_words = 4;
  localparam data_t sys_id        = 32'h5359_5301;

  // GPIO region offsets
  localparam addr_t gpio_out_off = 32'h0000_0000;
  localparam addr_t gpio_dir_off = 32'h0000_0004;
  localparam addr_t gpio_in_off  = 32'h0000_0008;

endpackage

`default_nettype wire

/* logic/host_bridge.sv */
////////////////////////////////////////
// Four-phase req/ack host port to AXI4-lite master
// One access in flight; host must hold fields until ack rises
// Protection bits are not driven
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module host_bridge import sys_pkg::*; (
  input  logic  aclk,
  input  logic  reset,
  // Host port
  input  logic  req,
  input  logic  we,
  input  addr_t addr,
  input  data_t wdata,
  input  strb_t strb,
  output logic  ack,
  output data_t rdata,
  output resp_t resp,
  // AXI4-lite master
  output logic  awvalid,
  input  logic  awready,
  output addr_t awaddr,
  output logic  wvalid,
  input  logic  wready,
  output data_t wdata_m,
  output strb_t wstrb,
  input  logic  bvalid,
  output logic  bready,
  input  resp_t bresp,
  output logic  arvalid,
  input  logic  arready,
  output addr_t araddr,
  input  logic  rvalid,
  output logic  rready,
  input  data_t rdata_m,
  input  resp_t rresp
);

  typedef enum logic [2:0] {
    idle,
    write_addr,
    read_addr,
    wait_resp,
    hold_ack,
    wait_release
  } bridge_state_t;

  bridge_state_t state;
  addr_t         addr_q;

  // Same captured address serves both channels
  assign awaddr = addr_q;
  assign araddr = addr_q;

  // Request payload captured with the request
  always_ff @(posedge aclk) begin
    if (state == idle && req) begin
      addr_q  <= addr;
      wdata_m <= wdata;
      wstrb   <= strb;
    end
  end

  // Response payload; writes return zero data
  always_ff @(posedge aclk) begin
    if (bvalid && bready) begin
      rdata <= '0;
      resp  <= bresp;
    end else if (rvalid && rready) begin
      rdata <= rdata_m;
      resp  <= rresp;
    end
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (reset) begin
      state   <= idle;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
      bready  <= 1'b0;
      rready  <= 1'b0;
      ack     <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (req) begin
            awvalid <= we;
            wvalid  <= we;
            arvalid <= !we;
            state   <= we ? write_addr : read_addr;
          end
        end
        write_addr: begin
          // Each valid drops on its own handshake
          if (awvalid && awready) awvalid <= 1'b0;
          if (wvalid && wready) wvalid <= 1'b0;
          if ((awready || !awvalid) && (wready || !wvalid)) begin
            bready <= 1'b1;
            state  <= wait_resp;
          end
        end
        read_addr: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= wait_resp;
          end
        end
        wait_resp: begin
          if ((bvalid && bready) || (rvalid && rready)) begin
            bready <= 1'b0;
            rready <= 1'b0;
            ack    <= 1'b1;
            state  <= hold_ack;
          end
        end
        hold_ack: begin
          // Close the four-phase cycle once the host drops req
          if (!req) begin
            ack   <= 1'b0;
            state <= wait_release;
          end
        end
        // One turnaround cycle before the next request
        wait_release: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Ack only ever answers a live request
  assert property (@(posedge aclk) disable iff (reset) $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

/* logic/axi_decoder.sv */
////////////////////////////////////////
// AXI4-lite 1-to-2 decoder, no added latency on routed paths
// Unmapped regions answered here with DECERR and zero data
// One transaction at a time; new addresses wait while busy
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_decoder import sys_pkg::*; (
  input  logic  aclk,
  input  logic  reset,
  // From the bridge
  input  logic  awvalid,
  output logic  awready,
  input  addr_t awaddr,
  input  logic  wvalid,
  output logic  wready,
  input  data_t wdata,
  input  strb_t wstrb,
  output logic  bvalid,
  input  logic  bready,
  output resp_t bresp,
  input  logic  arvalid,
  output logic  arready,
  input  addr_t araddr,
  output logic  rvalid,
  input  logic  rready,
  output data_t rdata,
  output resp_t rresp,
  // Scratch slave
  output logic  s0_awvalid,
  input  logic  s0_awready,
  output addr_t s0_awaddr,
  output logic  s0_wvalid,
  input  logic  s0_wready,
  output data_t s0_wdata,
  output strb_t s0_wstrb,
  input  logic  s0_bvalid,
  output logic  s0_bready,
  input  resp_t s0_bresp,
  output logic  s0_arvalid,
  input  logic  s0_arready,
  output addr_t s0_araddr,
  input  logic  s0_rvalid,
  output logic  s0_rready,
  input  data_t s0_rdata,
  input  resp_t s0_rresp,
  // GPIO slave
  output logic  s1_awvalid,
  input  logic  s1_awready,
  output addr_t s1_awaddr,
  output logic  s1_wvalid,
  input  logic  s1_wready,
  output data_t s1_wdata,
  output strb_t s1_wstrb,
  input  logic  s1_bvalid,
  output logic  s1_bready,
  input  resp_t s1_bresp,
  output logic  s1_arvalid,
  input  logic  s1_arready,
  output addr_t s1_araddr,
  input  logic  s1_rvalid,
  output logic  s1_rready,
  input  data_t s1_rdata,
  input  resp_t s1_rresp
);

  typedef enum logic [2:0] {
    idle,
    busy_write,
    busy_read,
    err_write,
    err_read
  } dec_state_t;

  dec_state_t state;
  logic       tgt_gpio;
  logic       aw_s0;
  logic       aw_s1;
  logic       ar_s0;
  logic       ar_s1;

  // Region hits
  assign aw_s0 = (awaddr & region_mask) == scratch_base;
  assign aw_s1 = (awaddr & region_mask) == gpio_base;
  assign ar_s0 = (araddr & region_mask) == scratch_base;
  assign ar_s1 = (araddr & region_mask) == gpio_base;

  // Payload fans out to both slaves
  assign s0_awaddr = awaddr;
  assign s0_wdata  = wdata;
  assign s0_wstrb  = wstrb;
  assign s0_araddr = araddr;
  assign s1_awaddr = awaddr;
  assign s1_wdata  = wdata;
  assign s1_wstrb  = wstrb;
  assign s1_araddr = araddr;

  ////////////////////////////////////////
  // Request routing, idle only
  ////////////////////////////////////////
  assign s0_awvalid = (state == idle) && awvalid && aw_s0;
  assign s0_wvalid  = (state == idle) && wvalid && aw_s0;
  assign s1_awvalid = (state == idle) && awvalid && aw_s1;
  assign s1_wvalid  = (state == idle) && wvalid && aw_s1;
  assign s0_arvalid = (state == idle) && arvalid && ar_s0;
  assign s1_arvalid = (state == idle) && arvalid && ar_s1;

  always_comb begin
    awready = 1'b0;
    wready  = 1'b0;
    arready = 1'b0;
    if (state == idle) begin
      // Unmapped: take address and data together at once
      awready = aw_s0 ? s0_awready : aw_s1 ? s1_awready : (awvalid && wvalid);
      wready  = aw_s0 ? s0_wready : aw_s1 ? s1_wready : (awvalid && wvalid);
      arready = ar_s0 ? s0_arready : ar_s1 ? s1_arready : arvalid;
    end
  end

  // Response channels follow the latched target
  assign s0_bready = (state == busy_write) && !tgt_gpio && bready;
  assign s1_bready = (state == busy_write) && tgt_gpio && bready;
  assign s0_rready = (state == busy_read) && !tgt_gpio && rready;
  assign s1_rready = (state == busy_read) && tgt_gpio && rready;

  always_comb begin
    bvalid = 1'b0;
    bresp  = resp_okay;
    rvalid = 1'b0;
    rdata  = '0;
    rresp  = resp_okay;
    case (state)
      busy_write: begin
        bvalid = tgt_gpio ? s1_bvalid : s0_bvalid;
        bresp  = tgt_gpio ? s1_bresp : s0_bresp;
      end
      busy_read: begin
        rvalid = tgt_gpio ? s1_rvalid : s0_rvalid;
        rdata  = tgt_gpio ? s1_rdata : s0_rdata;
        rresp  = tgt_gpio ? s1_rresp : s0_rresp;
      end
      err_write: begin
        bvalid = 1'b1;
        bresp  = resp_decerr;
      end
      err_read: begin
        rvalid = 1'b1;
        rresp  = resp_decerr;
      end
      default: ;
    endcase
  end

  // Pending transaction tracker
  always_ff @(posedge aclk) begin
    if (reset) begin
      state    <= idle;
      tgt_gpio <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (awvalid && awready) begin
            tgt_gpio <= aw_s1;
            state    <= (aw_s0 || aw_s1) ? busy_write : err_write;
          end else if (arvalid && arready) begin
            tgt_gpio <= ar_s1;
            state    <= (ar_s0 || ar_s1) ? busy_read : err_read;
          end
        end
        busy_write, err_write: if (bvalid && bready) state <= idle;
        busy_read, err_read: if (rvalid && rready) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Single master never issues a read and a write at once
  assert property (@(posedge aclk) disable iff (reset) !(awvalid && arvalid));

endmodule

`default_nettype wire

/* logic/scratch_regs.sv */
////////////////////////////////////////
// AXI4-lite slave, ID word plus four byte-writable scratch words
// Response one cycle after address; one access at a time
// Unused offsets and ID writes answer SLVERR
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module scratch_regs import sys_pkg::*; (
  input  logic  aclk,
  input  logic  reset,
  input  logic  awvalid,
  output logic  awready,
  input  addr_t awaddr,
  input  logic  wvalid,
  output logic  wready,
  input  data_t wdata,
  input  strb_t wstrb,
  output logic  bvalid,
  input  logic  bready,
  output resp_t bresp,
  input  logic  arvalid,
  output logic  arready,
  input  addr_t araddr,
  output logic  rvalid,
  input  logic  rready,
  output data_t rdata,
  output resp_t rresp
);

  data_t scratch [scratch_words];
  addr_t wr_off;
  addr_t rd_off;
  logic  wr_hit;
  logic  rd_hit;
  logic [$clog2(scratch_words)-1:0] wr_idx;
  logic [$clog2(scratch_words)-1:0] rd_idx;

  // Address and data taken together, held off while a response waits
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign arready = arvalid && !rvalid;

  ////////////////////////////////////////
  // Offset decode
  ////////////////////////////////////////
  assign wr_off = awaddr & offset_mask;
  assign rd_off = araddr & offset_mask;
  assign wr_hit = wr_off >= scratch_first && wr_off <= scratch_last && wr_off[1:0] == 2'b00;
  assign rd_hit = rd_off >= scratch_first && rd_off <= scratch_last && rd_off[1:0] == 2'b00;
  // Word index counts from the first scratch offset
  assign wr_idx = wr_off[2 +: $clog2(scratch_words)] - 1'b1;
  assign rd_idx = rd_off[2 +: $clog2(scratch_words)] - 1'b1;

  // Write channel and scratch storage
  always_ff @(posedge aclk) begin
    if (reset) begin
      bvalid <= 1'b0;
      bresp  <= resp_okay;
      for (int i = 0; i < scratch_words; i++) begin
        scratch[i] <= '0;
      end
    end else if (awvalid && awready) begin
      bvalid <= 1'b1;
      bresp  <= wr_hit ? resp_okay : resp_slverr;
      if (wr_hit) begin
        // Byte merge under strobes
        for (int b = 0; b < strb_width; b++) begin
          if (wstrb[b]) scratch[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // Read channel
  always_ff @(posedge aclk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (arvalid && arready) begin
      if (rd_off == id_off) begin
        rdata <= sys_id;
        rresp <= resp_okay;
      end else if (rd_hit) begin
        rdata <= scratch[rd_idx];
        rresp <= resp_okay;
      end else begin
        rdata <= '0;
        rresp <= resp_slverr;
      end
    end
  end

  // Write response held under back-pressure
  assert property (@(posedge aclk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

/* logic/gpio_regs.sv */
////////////////////////////////////////
// AXI4-lite slave for 8 tri-state GPIO pins
// Direction bit 1 means input; only the low byte strobe writes
// Input register lags the pins by two sync flops
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gpio_regs import sys_pkg::*; (
  input  logic           aclk,
  input  logic           reset,
  input  logic           awvalid,
  output logic           awready,
  input  addr_t          awaddr,
  input  logic           wvalid,
  output logic           wready,
  input  data_t          wdata,
  input  strb_t          wstrb,
  output logic           bvalid,
  input  logic           bready,
  output resp_t          bresp,
  input  logic           arvalid,
  output logic           arready,
  input  addr_t          araddr,
  output logic           rvalid,
  input  logic           rready,
  output data_t          rdata,
  output resp_t          rresp,
  // Pins
  output sys_pkg::gpio_t gpio_o,
  output sys_pkg::gpio_t gpio_t,
  input  sys_pkg::gpio_t gpio_i
);

  sys_pkg::gpio_t in_meta;
  sys_pkg::gpio_t in_sync;
  addr_t          wr_off;
  addr_t          rd_off;

  assign wr_off = awaddr & offset_mask;
  assign rd_off = araddr & offset_mask;

  // Same handshake rules as the scratch slave
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign arready = arvalid && !rvalid;

  // Two-flop input synchronizer
  always_ff @(posedge aclk) begin
    in_meta <= gpio_i;
    in_sync <= in_meta;
  end

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (reset) begin
      bvalid <= 1'b0;
      bresp  <= resp_okay;
      gpio_o <= '0;
      // All pins start as inputs
      gpio_t <= '1;
    end else if (awvalid && awready) begin
      bvalid <= 1'b1;
      bresp  <= resp_slverr;
      if (wr_off == gpio_out_off) begin
        bresp <= resp_okay;
        if (wstrb[0]) gpio_o <= wdata[gpio_width-1:0];
      end else if (wr_off == gpio_dir_off) begin
        bresp <= resp_okay;
        if (wstrb[0]) gpio_t <= wdata[gpio_width-1:0];
      end
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // Read side
  always_ff @(posedge aclk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (arvalid && arready) begin
      rresp <= resp_okay;
      case (rd_off)
        gpio_out_off: rdata <= data_t'(gpio_o);
        gpio_dir_off: rdata <= data_t'(gpio_t);
        gpio_in_off:  rdata <= data_t'(in_sync);
        default: begin
          rdata <= '0;
          rresp <= resp_slverr;
        end
      endcase
    end
  end

  // Read data held under back-pressure
  assert property (@(posedge aclk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* logic/sys_top.sv */
////////////////////////////////////////
// Host subsystem top: bridge, decoder, scratch and GPIO slaves
// Single clock and synchronous active-high reset
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_top import sys_pkg::*; (
  input  logic           aclk,
  input  logic           reset,
  // Host port
  input  logic           req,
  input  logic           we,
  input  addr_t          addr,
  input  data_t          wdata,
  input  strb_t          strb,
  output logic           ack,
  output data_t          rdata,
  output resp_t          resp,
  // GPIO pins
  output sys_pkg::gpio_t gpio_o,
  output sys_pkg::gpio_t gpio_t,
  input  sys_pkg::gpio_t gpio_i
);

  // Bridge to decoder
  logic  awvalid, awready, wvalid, wready, bvalid, bready;
  logic  arvalid, arready, rvalid, rready;
  addr_t awaddr, araddr;
  data_t wdata_m, rdata_m;
  strb_t wstrb;
  resp_t bresp, rresp;

  // Decoder to scratch slave
  logic  s0_awvalid, s0_awready, s0_wvalid, s0_wready, s0_bvalid, s0_bready;
  logic  s0_arvalid, s0_arready, s0_rvalid, s0_rready;
  addr_t s0_awaddr, s0_araddr;
  data_t s0_wdata, s0_rdata;
  strb_t s0_wstrb;
  resp_t s0_bresp, s0_rresp;

  // Decoder to GPIO slave
  logic  s1_awvalid, s1_awready, s1_wvalid, s1_wready, s1_bvalid, s1_bready;
  logic  s1_arvalid, s1_arready, s1_rvalid, s1_rready;
  addr_t s1_awaddr, s1_araddr;
  data_t s1_wdata, s1_rdata;
  strb_t s1_wstrb;
  resp_t s1_bresp, s1_rresp;

  host_bridge u_bridge (.*);

  // Bridge data names differ from the host port names
  axi_decoder u_decoder (
    .wdata (wdata_m),
    .rdata (rdata_m),
    .*
  );

  scratch_regs u_scratch (
    .aclk    (aclk),
    .reset   (reset),
    .awvalid (s0_awvalid),
    .awready (s0_awready),
    .awaddr  (s0_awaddr),
    .wvalid  (s0_wvalid),
    .wready  (s0_wready),
    .wdata   (s0_wdata),
    .wstrb   (s0_wstrb),
    .bvalid  (s0_bvalid),
    .bready  (s0_bready),
    .bresp   (s0_bresp),
    .arvalid (s0_arvalid),
    .arready (s0_arready),
    .araddr  (s0_araddr),
    .rvalid  (s0_rvalid),
    .rready  (s0_rready),
    .rdata   (s0_rdata),
    .rresp   (s0_rresp)
  );

  gpio_regs u_gpio (
    .aclk    (aclk),
    .reset   (reset),
    .awvalid (s1_awvalid),
    .awready (s1_awready),
    .awaddr  (s1_awaddr),
    .wvalid  (s1_wvalid),
    .wready  (s1_wready),
    .wdata   (s1_wdata),
    .wstrb   (s1_wstrb),
    .bvalid  (s1_bvalid),
    .bready  (s1_bready),
    .bresp   (s1_bresp),
    .arvalid (s1_arvalid),
    .arready (s1_arready),
    .araddr  (s1_araddr),
    .rvalid  (s1_rvalid),
    .rready  (s1_rready),
    .rdata   (s1_rdata),
    .rresp   (s1_rresp),
    .gpio_o  (gpio_o),
    .gpio_t  (gpio_t),
    .gpio_i  (gpio_i)
  );

endmodule

`default_nettype wire

/* bench/sys_ref_model.svh */
////////////////////////////////////////
// Register-map model and host access task for sys_tb
// Included inside the testbench module; uses its host port signals
// Regions decoded from address bits 15:12 only
////////////////////////////////////////
`ifndef SYS_REF_MODEL_SVH
`define SYS_REF_MODEL_SVH

  // Model registers
  data_t          scratch_model [scratch_words];
  sys_pkg::gpio_t out_model;
  sys_pkg::gpio_t dir_model;

  // One full four-phase handshake on the host port
  task automatic host_access(input logic wr, input addr_t a, input data_t d,
                             input strb_t s, output data_t got_data,
                             output resp_t got_resp);
    @(negedge aclk);
    we    = wr;
    addr  = a;
    wdata = d;
    strb  = s;
    req   = 1'b1;
    // Fields held until ack
    do @(negedge aclk); while (!ack);
    got_data = rdata;
    got_resp = resp;
    req      = 1'b0;
    do @(negedge aclk); while (ack);
  endtask

  // Expected response from the address map rules
  function automatic void predict(input logic wr, input addr_t a,
                                  output data_t exp_data, output resp_t exp_resp);
    addr_t off;
    logic  hit;
    off      = a & offset_mask;
    hit      = off >= 32'h4 && off <= 32'h10 && off[1:0] == 2'b00;
    exp_data = '0;
    exp_resp = resp_slverr;
    if ((a & region_mask) == scratch_base) begin
      if (hit) begin
        exp_resp = resp_okay;
        if (!wr) exp_data = scratch_model[off[3:2] - 2'd1];
      end else if (off == 0 && !wr) begin
        exp_data = sys_id;
        exp_resp = resp_okay;
      end
    end else if ((a & region_mask) == gpio_base) begin
      if (off == 32'h0 || off == 32'h4) exp_resp = resp_okay;
      if (off == 32'h8 && !wr) exp_resp = resp_okay;
      if (!wr && off == 32'h0) exp_data = data_t'(out_model);
      if (!wr && off == 32'h4) exp_data = data_t'(dir_model);
      if (!wr && off == 32'h8) exp_data = data_t'(gpio_in);
    end else begin
      exp_resp = resp_decerr;
    end
  endfunction

  // Model side effect of a write
  function automatic void apply_write(input addr_t a, input data_t d, input strb_t s);
    addr_t off;
    off = a & offset_mask;
    if ((a & region_mask) == scratch_base) begin
      if (off >= 32'h4 && off <= 32'h10 && off[1:0] == 2'b00) begin
        for (int b = 0; b < 4; b++) begin
          if (s[b]) scratch_model[off[3:2] - 2'd1][8*b +: 8] = d[8*b +: 8];
        end
      end
    end else if ((a & region_mask) == gpio_base && s[0]) begin
      // Low byte strobe only
      if (off == 32'h0) out_model = d[7:0];
      if (off == 32'h4) dir_model = d[7:0];
    end
  endfunction

`endif

/* bench/sys_tb.sv */
////////////////////////////////////////
// Random testbench for sys_top with fixed seed 68
// Inputs change and results are read on the falling edge
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_tb import sys_pkg::*; ();

  // Access budget per test sets the timeout
  localparam int planned_accesses = 1 + 400 + 48 + 80 + 10;
  localparam int timeout_cycles   = 40 * planned_accesses + 100;

  logic           aclk;
  logic           reset;
  logic           req;
  logic           we;
  addr_t          addr;
  data_t          wdata;
  strb_t          strb;
  logic           ack;
  data_t          rdata;
  resp_t          resp;
  sys_pkg::gpio_t gpio_out;
  sys_pkg::gpio_t gpio_dir;
  sys_pkg::gpio_t gpio_in;

  int             errors;
  int             passes;
  int             cycles;
  int             test_start;
  logic           req_d;
  logic           ack_d;
  logic           req_pending;
  data_t          scratch_snap [scratch_words];
  sys_pkg::gpio_t out_snap;
  sys_pkg::gpio_t dir_snap;
  addr_t          a;
  strb_t          s;

  sys_top DUT (
    .aclk   (aclk),
    .reset  (reset),
    .req    (req),
    .we     (we),
    .addr   (addr),
    .wdata  (wdata),
    .strb   (strb),
    .ack    (ack),
    .rdata  (rdata),
    .resp   (resp),
    .gpio_o (gpio_out),
    .gpio_t (gpio_dir),
    .gpio_i (gpio_in)
  );

  always #50 aclk = ~aclk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end else begin
      passes++;
    end
  endtask

  `include "sys_ref_model.svh"

  // Access, compare with prediction, then update model
  task automatic run_access(input logic wr, input addr_t a, input data_t d, input strb_t s);
    data_t exp_data;
    resp_t exp_resp;
    data_t got_data;
    resp_t got_resp;
    predict(wr, a, exp_data, exp_resp);
    host_access(wr, a, d, s, got_data, got_resp);
    check_value("rdata", exp_data, got_data);
    check_value("resp", exp_resp, got_resp);
    if (wr) apply_write(a, d, s);
  endtask

  // Read a register and compare it with a saved value
  task automatic read_compare(input string name, input addr_t a, input data_t expected);
    data_t got_data;
    resp_t got_resp;
    host_access(1'b0, a, '0, '0, got_data, got_resp);
    check_value(name, expected, got_data);
    check_value({name, " resp"}, resp_okay, got_resp);
  endtask

  task automatic report_test(input string name);
    $display("Test %s finished with %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  ////////////////////////////////////////
  // Handshake monitor
  ////////////////////////////////////////
  // Values read here are the ones from before this edge
  always @(posedge aclk) begin
    if (reset) begin
      req_d       <= 1'b0;
      ack_d       <= 1'b0;
      req_pending <= 1'b0;
    end else begin
      if (ack && !ack_d && !req_d) begin
        $display("At %0t ns ack rose while req was low", $time);
        errors++;
      end
      if (!ack && ack_d && req_d) begin
        $display("At %0t ns ack fell before req was released", $time);
        errors++;
      end
      if (ack && !ack_d && !req_pending) begin
        $display("At %0t ns ack appeared without a request", $time);
        errors++;
      end
      if (req && !req_d) req_pending <= 1'b1;
      else if (ack && !ack_d) req_pending <= 1'b0;
      req_d <= req;
      ack_d <= ack;
    end
  end

  // Cycle limit
  always @(posedge aclk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the host handshake hung", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    aclk        = 1'b0;
    reset       = 1'b1;
    req         = 1'b0;
    we          = 1'b0;
    addr        = '0;
    wdata       = '0;
    strb        = '0;
    gpio_in     = '0;
    errors      = 0;
    passes      = 0;
    cycles      = 0;
    test_start  = 0;
    out_model   = '0;
    dir_model   = '1;
    for (int i = 0; i < scratch_words; i++) scratch_model[i] = '0;
    void'($urandom(68));
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    reset = 1'b0;
    @(negedge aclk);

    // Reset state
    check_value("ack", 1'b0, ack);
    check_value("gpio_o", 8'h00, gpio_out);
    check_value("gpio_t", 8'hff, gpio_dir);
    run_access(1'b0, scratch_base | id_off, '0, '0);
    report_test("reset_state");

    // Scratch words with random reads between writes
    for (int i = 0; i < 200; i++) begin
      run_access(1'b1, scratch_base | addr_t'(4 * (1 + $urandom % 4)), $urandom, $urandom);
      if ($urandom % 2) run_access(1'b0, scratch_base | addr_t'(4 * (1 + $urandom % 4)), '0, '0);
    end
    report_test("scratch_words");

    // Error responses
    for (int i = 0; i < scratch_words; i++) scratch_snap[i] = scratch_model[i];
    out_snap = out_model;
    dir_snap = dir_model;
    for (int i = 0; i < 24; i++) begin
      a        = $urandom;
      a[15:12] = 4'(2 + $urandom % 14);
      run_access(1'($urandom), a, $urandom, $urandom);
    end
    run_access(1'b1, scratch_base | id_off, $urandom, 4'hf);
    run_access(1'b1, gpio_base | gpio_in_off, $urandom, 4'hf);
    for (int i = 0; i < 8; i++) begin
      run_access(1'($urandom), scratch_base | addr_t'(12'h014 + $urandom % 12'hfec),
                 $urandom, $urandom);
      run_access(1'($urandom), gpio_base | addr_t'(12'h00c + $urandom % 12'hff4),
                 $urandom, $urandom);
    end
    // Registers still hold what they had before the error accesses
    for (int i = 0; i < scratch_words; i++) begin
      read_compare("scratch word", scratch_base | addr_t'(4 * (i + 1)), scratch_snap[i]);
    end
    read_compare("gpio out reg", gpio_base | gpio_out_off, data_t'(out_snap));
    read_compare("gpio dir reg", gpio_base | gpio_dir_off, data_t'(dir_snap));
    report_test("error_responses");

    // GPIO outputs and direction
    for (int i = 0; i < 40; i++) begin
      a = gpio_base | (($urandom % 2) ? gpio_dir_off : gpio_out_off);
      s = $urandom;
      run_access(1'b1, a, $urandom, s);
      check_value("gpio_o", out_model, gpio_out);
      check_value("gpio_t", dir_model, gpio_dir);
      run_access(1'b0, a, '0, '0);
    end
    report_test("gpio_outputs");

    // GPIO inputs settle before the request
    for (int i = 0; i < 10; i++) begin
      @(negedge aclk);
      gpio_in = $urandom;
      repeat (3) @(negedge aclk);
      run_access(1'b0, gpio_base | gpio_in_off, '0, '0);
    end
    report_test("gpio_inputs");

    $display("Checks passed: %0d, errors: %0d", passes, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+bench
logic/sys_pkg.sv
logic/host_bridge.sv
logic/axi_decoder.sv
logic/scratch_regs.sv
logic/gpio_regs.sv
logic/sys_top.sv
bench/sys_tb.sv
